//--- verilog/pcs_rx_pkg.sv
// pcs receive package: widths, limits, encodings, register map and bus structs
`default_nettype none

package pcs_rx_pkg;

    // block geometry
    localparam int NB_BLOCK   = 66;
    localparam int NB_PAYLOAD = 64;
    localparam int NB_SH      = 2;
    localparam int NB_CTRL    = 8;
    localparam int NB_BYTE    = 8;

    // sync header lock limits
    localparam int SH_LOCK_COUNT    = 64;
    localparam int SH_WINDOW        = 1024;
    localparam int SH_INVALID_LIMIT = 16;
    localparam int NB_SLIP          = 7;
    localparam int NB_LOCK_CNT      = $clog2(SH_LOCK_COUNT);
    localparam int NB_WINDOW_CNT    = $clog2(SH_WINDOW);
    localparam int NB_INVALID_CNT   = $clog2(SH_INVALID_LIMIT);

    localparam logic [NB_SLIP-1:0]        SLIP_LAST    = NB_SLIP'(NB_BLOCK - 1);
    localparam logic [NB_LOCK_CNT-1:0]    LOCK_LAST    = NB_LOCK_CNT'(SH_LOCK_COUNT - 1);
    localparam logic [NB_WINDOW_CNT-1:0]  WINDOW_LAST  = NB_WINDOW_CNT'(SH_WINDOW - 1);
    localparam logic [NB_INVALID_CNT-1:0] INVALID_LAST = NB_INVALID_CNT'(SH_INVALID_LIMIT - 1);

    // x^58 + x^39 + 1
    localparam int SCRAMBLER_TAP_A = 58;
    localparam int SCRAMBLER_TAP_B = 39;

    // status counters and register bus
    localparam int                  NB_COUNT     = 16;
    localparam logic [NB_COUNT-1:0] COUNT_MAX    = '1;
    localparam int                  NB_AXIL_ADDR = 4;
    localparam int                  NB_AXIL_DATA = 32;
    localparam int                  NB_RESP      = 2;
    localparam logic [NB_RESP-1:0]  RESP_OKAY    = 2'b00;
    localparam logic [NB_RESP-1:0]  RESP_SLVERR  = 2'b10;

    // characters and headers
    localparam logic [NB_BYTE-1:0] CHAR_IDLE  = 8'h07;
    localparam logic [NB_BYTE-1:0] CHAR_START = 8'hFB;
    localparam logic [NB_BYTE-1:0] CHAR_TERM  = 8'hFD;
    localparam logic [NB_BYTE-1:0] CHAR_ERROR = 8'hFE;
    localparam logic [NB_SH-1:0]   SH_DATA    = 2'b01;
    localparam logic [NB_SH-1:0]   SH_CTRL    = 2'b10;

    typedef enum logic [7:0] {
        BT_IDLE  = 8'h1E,
        BT_START = 8'h78,
        BT_TERM0 = 8'h87,
        BT_TERM7 = 8'hFF
    } block_type_e;

    typedef enum logic [1:0] {
        LS_HUNT,
        LS_LOCKED,
        LS_SLIP
    } lock_state_e;

    typedef enum logic [NB_AXIL_ADDR-1:0] {
        REG_STATUS       = 4'h0,
        REG_ERROR_BLOCKS = 4'h4,
        REG_LOCK_LOSSES  = 4'h8
    } reg_addr_e;

    // payload bit 0 is the first bit on the line
    typedef struct packed {
        logic                  valid;
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } coded_block_t;

    typedef struct packed {
        logic                  valid;
        logic [NB_PAYLOAD-1:0] data;
        logic [NB_CTRL-1:0]    ctrl;
    } decoded_block_t;

    typedef struct packed {
        logic block_lock;
        logic lock_lost;
        logic error_block;
    } pcs_status_t;

    typedef struct packed {
        logic                    arvalid;
        logic [NB_AXIL_ADDR-1:0] araddr;
        logic                    rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic                    arready;
        logic                    rvalid;
        logic [NB_AXIL_DATA-1:0] rdata;
        logic [NB_RESP-1:0]      rresp;
    } axil_rd_rsp_t;

endpackage

`default_nettype wire

//--- verilog/block_lock.sv
// block lock: finds the 66-bit block boundary by sync header lock and bit slip
`default_nettype none
`timescale 1ns/1ns

module block_lock
    import pcs_rx_pkg::*;
(
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire logic                i_valid,
    input  wire logic [NB_BLOCK-1:0] i_data,
    output coded_block_t             o_block,
    output logic                     o_block_lock,
    output logic                     o_lock_lost
);

    logic [NB_BLOCK-1:0]       prev_word;
    logic [2*NB_BLOCK-1:0]     pair;
    logic [NB_BLOCK-1:0]       window;
    logic                      sh_valid;
    lock_state_e               state;
    logic [NB_SLIP-1:0]        slip;
    logic [NB_LOCK_CNT-1:0]    sh_count;
    logic [NB_WINDOW_CNT-1:0]  win_count;
    logic [NB_INVALID_CNT-1:0] inv_count;
    logic                      out_valid;
    logic [NB_SH-1:0]          out_sh;
    logic [NB_PAYLOAD-1:0]     out_payload;
    logic                      lock_lost;

    // earlier bits sit in the previous word
    assign pair = {i_data, prev_word};

    // slip counts how many bits of the block lie in the previous word
    assign window   = pair[NB_BLOCK - int'(slip) +: NB_BLOCK];
    assign sh_valid = ^window[NB_SH-1:0];

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            prev_word   <= i_data;
            out_sh      <= window[NB_SH-1:0];
            out_payload <= window[NB_BLOCK-1:NB_SH];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state     <= LS_HUNT;
            slip      <= '0;
            sh_count  <= '0;
            win_count <= '0;
            inv_count <= '0;
            lock_lost <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            lock_lost <= 1'b0;
            out_valid <= i_valid && (state == LS_LOCKED);
            case (state)
                LS_HUNT:
                    if (i_valid)
                    begin
                        if (!sh_valid)
                            state <= LS_SLIP;
                        else if (sh_count == LOCK_LAST)
                        begin
                            sh_count <= '0;
                            state    <= LS_LOCKED;
                        end
                        else
                            sh_count <= sh_count + 1'b1;
                    end
                LS_LOCKED:
                    if (i_valid)
                    begin
                        if (!sh_valid && inv_count == INVALID_LAST)
                        begin
                            lock_lost <= 1'b1;
                            state     <= LS_SLIP;
                        end
                        else if (win_count == WINDOW_LAST)
                        begin
                            // window done, start a fresh one
                            win_count <= '0;
                            inv_count <= '0;
                        end
                        else
                        begin
                            win_count <= win_count + 1'b1;
                            if (!sh_valid)
                                inv_count <= inv_count + 1'b1;
                        end
                    end
                LS_SLIP:
                begin
                    slip      <= (slip == SLIP_LAST) ? '0 : slip + 1'b1;
                    sh_count  <= '0;
                    win_count <= '0;
                    inv_count <= '0;
                    state     <= LS_HUNT;
                end
                default:
                    state <= LS_HUNT;
            endcase
        end
    end

    assign o_block      = '{valid: out_valid, sh: out_sh, payload: out_payload};
    assign o_block_lock = (state == LS_LOCKED);
    assign o_lock_lost  = lock_lost;

endmodule

`default_nettype wire

//--- verilog/descrambler.sv
// descrambler: undoes the self-synchronizing x^58 + x^39 + 1 payload scrambling
`default_nettype none
`timescale 1ns/1ns

module descrambler
    import pcs_rx_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire coded_block_t i_block,
    output coded_block_t      o_block
);

    logic [SCRAMBLER_TAP_A-1:0]            history;
    logic [NB_PAYLOAD+SCRAMBLER_TAP_A-1:0] ext;
    logic [NB_PAYLOAD-1:0]                 clear_bits;
    logic                                  out_valid;
    logic [NB_SH-1:0]                      out_sh;
    logic [NB_PAYLOAD-1:0]                 out_payload;

    // received scrambled bits in line order, oldest at bit 0
    assign ext = {i_block.payload, history};

    always_comb
    begin
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            clear_bits[i] = ext[i + SCRAMBLER_TAP_A]
                          ^ ext[i + SCRAMBLER_TAP_A - SCRAMBLER_TAP_B]
                          ^ ext[i];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            history   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= i_block.valid;
            // keep the last 58 received bits
            if (i_block.valid)
                history <= ext[NB_PAYLOAD+SCRAMBLER_TAP_A-1 -: SCRAMBLER_TAP_A];
        end
    end

    always_ff @(posedge i_clock)
    begin
        out_sh      <= i_block.sh;
        out_payload <= clear_bits;
    end

    assign o_block = '{valid: out_valid, sh: out_sh, payload: out_payload};

endmodule

`default_nettype wire

//--- verilog/block_decoder.sv
// block decoder: maps descrambled 64b/66b blocks to data bytes and control flags
`default_nettype none
`timescale 1ns/1ns

module block_decoder
    import pcs_rx_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire coded_block_t i_block,
    output decoded_block_t    o_block,
    output logic              o_error_block
);

    block_type_e           block_type;
    logic [NB_PAYLOAD-1:0] dec_data;
    logic [NB_CTRL-1:0]    dec_ctrl;
    logic                  dec_error;
    logic                  out_valid;
    logic [NB_PAYLOAD-1:0] out_data;
    logic [NB_CTRL-1:0]    out_ctrl;
    logic                  out_error;

    // type field is the first payload byte
    assign block_type = block_type_e'(i_block.payload[NB_BYTE-1:0]);

    always_comb
    begin
        dec_data  = {NB_CTRL{CHAR_ERROR}};
        dec_ctrl  = '1;
        dec_error = 1'b1;
        if (i_block.sh == SH_DATA)
        begin
            dec_data  = i_block.payload;
            dec_ctrl  = '0;
            dec_error = 1'b0;
        end
        else if (i_block.sh == SH_CTRL)
        begin
            case (block_type)
                BT_IDLE:
                begin
                    dec_data  = {NB_CTRL{CHAR_IDLE}};
                    dec_error = 1'b0;
                end
                BT_START:
                begin
                    // start in lane 0, seven data bytes behind it
                    dec_data  = {i_block.payload[NB_PAYLOAD-1:NB_BYTE], CHAR_START};
                    dec_ctrl  = {{(NB_CTRL-1){1'b0}}, 1'b1};
                    dec_error = 1'b0;
                end
                BT_TERM0:
                begin
                    dec_data  = {{(NB_CTRL-1){CHAR_IDLE}}, CHAR_TERM};
                    dec_error = 1'b0;
                end
                BT_TERM7:
                begin
                    dec_data  = {CHAR_TERM, i_block.payload[NB_PAYLOAD-1:NB_BYTE]};
                    dec_ctrl  = {1'b1, {(NB_CTRL-1){1'b0}}};
                    dec_error = 1'b0;
                end
                default:
                    dec_error = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            out_valid <= 1'b0;
            out_error <= 1'b0;
        end
        else
        begin
            out_valid <= i_block.valid;
            out_error <= i_block.valid && dec_error;
        end
    end

    always_ff @(posedge i_clock)
    begin
        out_data <= dec_data;
        out_ctrl <= dec_ctrl;
    end

    assign o_block       = '{valid: out_valid, data: out_data, ctrl: out_ctrl};
    assign o_error_block = out_error;

endmodule

`default_nettype wire

//--- verilog/status_regs.sv
// status registers: clear-on-read pcs counters behind an AXI4-Lite read port
`default_nettype none
`timescale 1ns/1ns

module status_regs
    import pcs_rx_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_reset,
    input  wire pcs_status_t  i_status,
    input  wire axil_rd_req_t i_axil_req,
    output axil_rd_rsp_t      o_axil_rsp
);

    logic [NB_COUNT-1:0]     error_count;
    logic [NB_COUNT-1:0]     loss_count;
    logic                    arready;
    logic                    rvalid;
    logic                    rvalid_next;
    logic [NB_AXIL_DATA-1:0] rdata;
    logic [NB_RESP-1:0]      rresp;
    logic [NB_AXIL_ADDR-1:0] rd_addr;
    logic                    ar_hs;
    logic                    r_hs;
    logic                    clear_errors;
    logic                    clear_losses;
    logic [NB_AXIL_DATA-1:0] read_data;
    logic [NB_RESP-1:0]      read_resp;

    // subtract what was reported so events during a stalled read survive
    function automatic logic [NB_COUNT-1:0] next_count(
        input logic [NB_COUNT-1:0] count,
        input logic                clear,
        input logic [NB_COUNT-1:0] taken,
        input logic                hit
    );
        logic [NB_COUNT-1:0] rest;
        rest = clear ? count - taken : count;
        if (hit && rest != COUNT_MAX)
            rest = rest + 1'b1;
        return rest;
    endfunction

    assign ar_hs       = i_axil_req.arvalid && arready;
    assign r_hs        = rvalid && i_axil_req.rready;
    assign rvalid_next = ar_hs || (rvalid && !r_hs);

    assign clear_errors = r_hs && (rd_addr == REG_ERROR_BLOCKS);
    assign clear_losses = r_hs && (rd_addr == REG_LOCK_LOSSES);

    always_comb
    begin
        read_data = '0;
        read_resp = RESP_OKAY;
        case (reg_addr_e'(i_axil_req.araddr))
            REG_STATUS:
                read_data = {{(NB_AXIL_DATA-1){1'b0}}, i_status.block_lock};
            REG_ERROR_BLOCKS:
                read_data = {{(NB_AXIL_DATA-NB_COUNT){1'b0}}, error_count};
            REG_LOCK_LOSSES:
                read_data = {{(NB_AXIL_DATA-NB_COUNT){1'b0}}, loss_count};
            default:
                read_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            error_count <= '0;
            loss_count  <= '0;
        end
        else
        begin
            rvalid      <= rvalid_next;
            // one outstanding read at a time
            arready     <= !rvalid_next;
            error_count <= next_count(error_count, clear_errors,
                                      rdata[NB_COUNT-1:0], i_status.error_block);
            loss_count  <= next_count(loss_count, clear_losses,
                                      rdata[NB_COUNT-1:0], i_status.lock_lost);
        end
    end

    // response payload held until rready
    always_ff @(posedge i_clock)
    begin
        if (ar_hs)
        begin
            rd_addr <= i_axil_req.araddr;
            rdata   <= read_data;
            rresp   <= read_resp;
        end
    end

    assign o_axil_rsp = '{arready: arready, rvalid: rvalid, rdata: rdata, rresp: rresp};

endmodule

`default_nettype wire

//--- verilog/pcs_rx_top.sv
// pcs receive top: block lock, descrambler, decoder and status register block
`default_nettype none
`timescale 1ns/1ns

module pcs_rx_top
    import pcs_rx_pkg::*;
(
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire logic                i_valid,
    input  wire logic [NB_BLOCK-1:0] i_data,
    output wire decoded_block_t      o_block,
    output wire logic                o_block_lock,
    input  wire axil_rd_req_t        i_axil_req,
    output wire axil_rd_rsp_t        o_axil_rsp
);

    wire coded_block_t locked_block;
    wire coded_block_t clear_block;
    wire pcs_status_t  status;
    wire logic         block_lock;
    wire logic         lock_lost;
    wire logic         error_block;

    block_lock u_block_lock (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .o_block      (locked_block),
        .o_block_lock (block_lock),
        .o_lock_lost  (lock_lost)
    );

    descrambler u_descrambler (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_block (locked_block),
        .o_block (clear_block)
    );

    block_decoder u_block_decoder (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_block       (clear_block),
        .o_block       (o_block),
        .o_error_block (error_block)
    );

    // status fields gathered from both ends of the chain
    assign status = '{block_lock: block_lock, lock_lost: lock_lost, error_block: error_block};

    status_regs u_status_regs (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_status   (status),
        .i_axil_req (i_axil_req),
        .o_axil_rsp (o_axil_rsp)
    );

    assign o_block_lock = block_lock;

endmodule

`default_nettype wire

//--- test/tb_pcs_rx_model.svh
// pcs receive model: 64b/66b block builders, payload scrambler and word slicer
`ifndef TB_PCS_RX_MODEL_SVH
`define TB_PCS_RX_MODEL_SVH

typedef enum int {
    KIND_IDLE,
    KIND_DATA,
    KIND_START,
    KIND_TERM0,
    KIND_TERM7,
    KIND_BAD00,
    KIND_BAD11
} block_kind_e;

// clear block on the line plus the decode the receiver should give back
typedef struct packed {
    logic [NB_SH-1:0]      sh;
    logic [NB_PAYLOAD-1:0] payload;
    logic [NB_PAYLOAD-1:0] exp_data;
    logic [NB_CTRL-1:0]    exp_ctrl;
} tb_block_t;

int                         off;
logic [SCRAMBLER_TAP_A-1:0] scr_state;
logic [NB_BLOCK-1:0]        prev_block;
logic [31:0]                next_seq;

task automatic init_model();
    logic [63:0] seed_bits;
    off        = int'($urandom % NB_BLOCK);
    seed_bits  = {$urandom, $urandom};
    scr_state  = seed_bits[SCRAMBLER_TAP_A-1:0];
    prev_block = '0;
    next_seq   = '0;
endtask

// s[i] = d[i] ^ s[i-39] ^ s[i-58], line order with bit 0 first
function automatic logic [NB_PAYLOAD-1:0] scramble_payload(input logic [NB_PAYLOAD-1:0] d);
    logic [NB_PAYLOAD+SCRAMBLER_TAP_A-1:0] ext;
    ext = {{NB_PAYLOAD{1'b0}}, scr_state};
    for (int i = 0; i < NB_PAYLOAD; i++)
    begin
        ext[i + SCRAMBLER_TAP_A] = d[i] ^ ext[i + SCRAMBLER_TAP_A - SCRAMBLER_TAP_B] ^ ext[i];
    end
    scr_state = ext[NB_PAYLOAD+SCRAMBLER_TAP_A-1 -: SCRAMBLER_TAP_A];
    return ext[NB_PAYLOAD+SCRAMBLER_TAP_A-1 -: NB_PAYLOAD];
endfunction

function automatic tb_block_t build_block(input block_kind_e kind);
    tb_block_t   blk;
    logic [63:0] rnd;
    logic [55:0] body;
    rnd  = {$urandom, $urandom};
    body = rnd[63:8];
    blk.sh       = SH_CTRL;
    blk.exp_ctrl = '1;
    case (kind)
        KIND_IDLE:
        begin
            blk.payload  = {56'h0, BT_IDLE};
            blk.exp_data = {NB_CTRL{CHAR_IDLE}};
        end
        KIND_DATA:
        begin
            // sequence number in the low four bytes
            blk.sh       = SH_DATA;
            blk.payload  = {rnd[63:32], next_seq};
            blk.exp_data = blk.payload;
            blk.exp_ctrl = '0;
            next_seq     = next_seq + 1;
        end
        KIND_START:
        begin
            blk.payload  = {body, BT_START};
            blk.exp_data = {body, CHAR_START};
            blk.exp_ctrl = 8'h01;
        end
        KIND_TERM0:
        begin
            blk.payload  = {56'h0, BT_TERM0};
            blk.exp_data = {{(NB_CTRL-1){CHAR_IDLE}}, CHAR_TERM};
        end
        KIND_TERM7:
        begin
            blk.payload  = {body, BT_TERM7};
            blk.exp_data = {CHAR_TERM, body};
            blk.exp_ctrl = 8'h80;
        end
        default:
        begin
            blk.sh       = (kind == KIND_BAD00) ? 2'b00 : 2'b11;
            blk.payload  = rnd;
            blk.exp_data = {NB_CTRL{CHAR_ERROR}};
        end
    endcase
    return blk;
endfunction

// the serializer word straddles two blocks at the chosen bit offset
function automatic logic [NB_BLOCK-1:0] cut_word(input logic [NB_BLOCK-1:0] coded);
    logic [2*NB_BLOCK-1:0] pair;
    pair       = {coded, prev_block};
    prev_block = coded;
    return pair[off +: NB_BLOCK];
endfunction

`endif

//--- test/tb_pcs_rx.sv
// pcs receive testbench: lock, decode, error, lock loss and register read checks
`default_nettype none
`timescale 1ns/1ns

module tb_pcs_rx
    import pcs_rx_pkg::*;
();

    localparam int CLOCK_PERIOD    = 8;
    localparam int LOCK_BLOCKS     = (SH_LOCK_COUNT + 1) * NB_BLOCK * 2;
    localparam int TEST_BLOCKS     = 400;
    localparam int WATCHDOG_CYCLES = 2 * LOCK_BLOCKS + TEST_BLOCKS;

    logic                i_clock;
    logic                i_reset;
    logic                i_valid;
    logic [NB_BLOCK-1:0] i_data;
    decoded_block_t      o_block;
    logic                o_block_lock;
    axil_rd_req_t        i_axil_req;
    axil_rd_rsp_t        o_axil_rsp;

    `include "tb_pcs_rx_model.svh"

    // last eight blocks sent, indexed by block number
    tb_block_t   expected_ring [8];
    int          blk_num;
    int          skip_count;
    logic        seq_known;
    logic [31:0] last_seq;

    pcs_rx_top i_pcs_rx_top (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .o_block      (o_block),
        .o_block_lock (o_block_lock),
        .i_axil_req   (i_axil_req),
        .o_axil_rsp   (o_axil_rsp)
    );

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    initial
    begin
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        report_failure("the run did not finish in time, lock or a register read never came");
    end

    // valid must trace back to lock three stages earlier
    valid_only_when_locked: assert property (@(posedge i_clock) disable iff (i_reset)
        o_block.valid |-> $past(o_block_lock, 3))
    else report_mismatch("decoded block valid while the lane was not locked");

    read_data_held: assert property (@(posedge i_clock) disable iff (i_reset)
        o_axil_rsp.rvalid && !i_axil_req.rready |=> o_axil_rsp.rvalid && $stable(o_axil_rsp.rdata))
    else report_mismatch("read response changed before rready");

    task automatic check_output();
        tb_block_t exp;
        if (!o_block.valid)
        begin
            skip_count = 0;
            seq_known  = 1'b0;
        end
        else if (skip_count < 2)
            // descrambler still refilling its history
            skip_count++;
        else
        begin
            exp = expected_ring[(blk_num + 4) % 8];
            assert (o_block.data == exp.exp_data && o_block.ctrl == exp.exp_ctrl)
            else report_mismatch($sformatf("decoded %h/%h, expected %h/%h", o_block.data,
                                           o_block.ctrl, exp.exp_data, exp.exp_ctrl));
            if (exp.sh == SH_DATA)
            begin
                if (seq_known)
                    assert (o_block.data[31:0] == last_seq + 1)
                    else report_mismatch($sformatf("sequence %0d after %0d",
                                                   o_block.data[31:0], last_seq));
                last_seq  = o_block.data[31:0];
                seq_known = 1'b1;
            end
        end
    endtask

    task automatic send_block(input block_kind_e kind);
        tb_block_t blk;
        @(negedge i_clock);
        check_output();
        blk = build_block(kind);
        expected_ring[blk_num % 8] = blk;
        blk_num++;
        i_valid = 1'b1;
        i_data  = cut_word({scramble_payload(blk.payload), blk.sh});
    endtask

    task automatic send_mixed(input int count);
        repeat (count)
            send_block(($urandom % 4 == 0) ? KIND_IDLE : KIND_DATA);
    endtask

    task automatic wait_for_lock();
        while (!o_block_lock)
            send_block(($urandom % 4 == 0) ? KIND_IDLE : KIND_DATA);
    endtask

    task automatic read_reg(input logic [NB_AXIL_ADDR-1:0] addr, input int stall,
                            output logic [NB_AXIL_DATA-1:0] data,
                            output logic [NB_RESP-1:0] resp);
        logic [NB_AXIL_DATA-1:0] held_data;
        logic [NB_RESP-1:0]      held_resp;
        send_block(KIND_DATA);
        i_axil_req = '{arvalid: 1'b1, araddr: addr, rready: 1'b0};
        while (!o_axil_rsp.arready)
            send_block(KIND_DATA);
        send_block(KIND_DATA);
        i_axil_req.arvalid = 1'b0;
        assert (o_axil_rsp.rvalid && !o_axil_rsp.arready)
        else report_mismatch("no read response one cycle after the address handshake");
        held_data = o_axil_rsp.rdata;
        held_resp = o_axil_rsp.rresp;
        repeat (stall)
        begin
            send_block(KIND_DATA);
            assert (o_axil_rsp.rvalid && !o_axil_rsp.arready &&
                    o_axil_rsp.rdata == held_data && o_axil_rsp.rresp == held_resp)
            else report_mismatch("read response not held while rready was low");
        end
        i_axil_req.rready = 1'b1;
        data = held_data;
        resp = held_resp;
        send_block(KIND_DATA);
        i_axil_req.rready = 1'b0;
        assert (!o_axil_rsp.rvalid)
        else report_mismatch("rvalid still high after the response was taken");
    endtask

    initial
    begin
        logic [NB_AXIL_DATA-1:0] value;
        logic [NB_RESP-1:0]      resp;
        void'($urandom(99));
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_data     = '0;
        i_axil_req = '0;
        blk_num    = 0;
        skip_count = 0;
        seq_known  = 1'b0;
        last_seq   = '0;
        init_model();
        repeat (2) @(negedge i_clock);
        assert (!o_block.valid && !o_block_lock && !o_axil_rsp.arready && !o_axil_rsp.rvalid)
        else report_mismatch("outputs not idle in reset");
        i_reset = 1'b0;

        // lock at a random bit offset, then decode every block kind
        wait_for_lock();
        send_mixed(12);
        send_block(KIND_START);
        repeat (3) send_block(KIND_DATA);
        send_block(KIND_TERM7);
        send_block(KIND_IDLE);
        send_block(KIND_START);
        send_block(KIND_DATA);
        send_block(KIND_TERM0);
        send_mixed(6);

        // drop any error counted while the descrambler resynchronized
        read_reg(REG_ERROR_BLOCKS, 0, value, resp);
        assert (resp == RESP_OKAY)
        else report_mismatch($sformatf("error blocks clearing read resp %0b", resp));

        // three bad headers while locked
        send_block(KIND_BAD00);
        send_block(KIND_DATA);
        send_block(KIND_BAD11);
        send_block(KIND_DATA);
        send_block(KIND_BAD00);
        repeat (4) send_block(KIND_DATA);
        read_reg(REG_ERROR_BLOCKS, 0, value, resp);
        assert (value == 3 && resp == RESP_OKAY)
        else report_mismatch($sformatf("error blocks read %0d resp %0b", value, resp));
        read_reg(REG_ERROR_BLOCKS, 0, value, resp);
        assert (value == 0 && resp == RESP_OKAY)
        else report_mismatch($sformatf("error blocks after clear read %0d", value));

        // rready stall and an unmapped address
        read_reg(REG_STATUS, 3, value, resp);
        assert (value == 1 && resp == RESP_OKAY)
        else report_mismatch($sformatf("status read %h resp %0b", value, resp));
        read_reg(4'hC, 0, value, resp);
        assert (value == 0 && resp == RESP_SLVERR)
        else report_mismatch($sformatf("unmapped read %h resp %0b", value, resp));

        // burst of bad headers inside one window
        for (int i = 0; i < SH_INVALID_LIMIT; i++)
            send_block((i % 2 == 0) ? KIND_BAD00 : KIND_BAD11);
        repeat (2) send_block(KIND_DATA);
        assert (!o_block_lock)
        else report_mismatch("lock held through a window of bad headers");
        wait_for_lock();
        send_mixed(8);
        read_reg(REG_LOCK_LOSSES, 0, value, resp);
        assert (value == 1 && resp == RESP_OKAY)
        else report_mismatch($sformatf("lock losses read %0d resp %0b", value, resp));
        read_reg(REG_STATUS, 0, value, resp);
        assert (value == 1 && resp == RESP_OKAY)
        else report_mismatch($sformatf("status after relock read %h", value));

        send_mixed(4);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+test
verilog/pcs_rx_pkg.sv
verilog/block_lock.sv
verilog/descrambler.sv
verilog/block_decoder.sv
verilog/status_regs.sv
verilog/pcs_rx_top.sv
test/tb_pcs_rx.sv

//--- run_sim.sh
#!/bin/sh
# builds the pcs receive testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pcs_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pcs_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
echo "pass message not found"
exit 1
